/* common/mvu_pkg.sv */
package mvu_pkg;

    // Memory address widths
    localparam int BDBANKA = 15;                // Data bank address bits
    localparam int BWBANKA = 9;                 // Weight bank address bits

    // Configuration field widths
    localparam int BLENGTH = 15;                // Length fields, programmed as length-1
    localparam int BPREC   = 6;                 // Precision fields, programmed as bits-1
    localparam int BCNTDWN = 29;                // Job countdown

    // Datapath pipeline depths that the control strobes must track
    localparam int MEMRDLATENCY  = 2;           // Memory read latency
    localparam int VVPSTAGES     = 3;           // Vector-product pipeline
    localparam int MAXPOOLSTAGES = 1;           // Max-pool stage

    // Strobe retiming, in cycles after the address leaves the AGU
    localparam int ACC_DELAY     = VVPSTAGES + MEMRDLATENCY + 1;   // Accumulator control
    localparam int SH_DELAY      = VVPSTAGES + MEMRDLATENCY;       // Shift lands one early
    localparam int OUTLOAD_DELAY = ACC_DELAY + MAXPOOLSTAGES;      // Output base load

    // Address and stride types
    typedef logic [BDBANKA-1:0] data_addr_t;    // Data address or stride
    typedef logic [BWBANKA-1:0] weight_addr_t;  // Weight address or stride

    // Configuration types
    typedef logic [BLENGTH-1:0] length_t;       // Dimension length minus one
    typedef logic [BPREC-1:0]   prec_t;         // Precision minus one
    typedef logic [BCNTDWN-1:0] cntdwn_t;       // Run window in cycles

endpackage

/* hdl/delay_line.sv */
`timescale 1ns/1ps

module delay_line #(
    parameter int DEPTH = 1                     // Cycles of delay, at least one
) (
    input  logic clk,
    input  logic rst_n,
    input  logic din,                           // Strobe in
    output logic dout                           // Same strobe DEPTH cycles later
);

    logic [DEPTH-1:0] sr;                       // Stage 0 takes the input

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sr <= '0;                           // No stray strobes after reset
        end else begin
            sr[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    assign dout = sr[DEPTH-1];

endmodule

/* hdl/mvu_controller.sv */
`timescale 1ns/1ps

module mvu_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,            // One-cycle job start
    input  mvu_pkg::cntdwn_t  countdown,        // Number of run cycles
    output logic              run,              // Job run window
    output logic              done,             // Held until next accepted start
    output logic              irq               // One-cycle end of job pulse
);

    import mvu_pkg::*;

    cntdwn_t cnt;                               // Run cycles left after this one

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            run  <= 1'b0;
            done <= 1'b0;
            irq  <= 1'b0;
        end else if (start && !run) begin      // Starts are taken only when idle
            if (countdown == '0) begin          // Empty job finishes at once
                run  <= 1'b0;
                done <= 1'b1;
                irq  <= 1'b1;
            end else begin
                cnt  <= countdown - 1'b1;
                run  <= 1'b1;
                done <= 1'b0;                   // Falls with the rise of run
                irq  <= 1'b0;
            end
        end else if (run) begin
            if (cnt == '0) begin                // Last run cycle
                run  <= 1'b0;
                done <= 1'b1;
                irq  <= 1'b1;
            end else begin
                cnt  <= cnt - 1'b1;
                irq  <= 1'b0;
            end
        end else begin
            irq <= 1'b0;                        // Interrupt is a single pulse
        end
    end

    // The interrupt only ever fires alongside a finished job
    a_irq_done : assert property (@(posedge clk) disable iff (!rst_n) irq |-> done);

    // A job is either running or finished, never both
    a_run_done : assert property (@(posedge clk) disable iff (!rst_n) !(run && done));

endmodule

/* agu/mvu_agu.sv */
`timescale 1ns/1ps

module mvu_agu #(
    parameter type addr_t = mvu_pkg::data_addr_t   // Data or weight address
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clr,               // Restart the walk
    input  logic             en,                // Advance one element
    input  addr_t            base_addr,         // First address of the block
    input  addr_t            stride0,           // Step along a row
    input  addr_t            stride1,           // Step between rows
    input  mvu_pkg::length_t length0,           // Row length minus one
    input  mvu_pkg::length_t length1,           // Row count minus one
    output addr_t            addr,              // Current read address
    output logic             row_end,           // Last element of a row
    output logic             block_end          // Last element of the block
);

    import mvu_pkg::*;

    length_t c0;                                // Position in the row
    length_t c1;                                // Row index
    addr_t   off0;                              // Running c0*stride0
    addr_t   off1;                              // Running c1*stride1
    logic    last0;                             // c0 at its length
    logic    last1;                             // c1 at its length

    assign last0 = (c0 == length0);
    assign last1 = (c1 == length1);

    // Offsets stand in for the two multiplies, wrapping at the address width
    assign addr = base_addr + off0 + off1;

    assign row_end   = en && last0;
    assign block_end = en && last0 && last1;

    // Inner dimension
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c0   <= '0;
            off0 <= '0;
        end else if (clr) begin
            c0   <= '0;
            off0 <= '0;
        end else if (en) begin
            if (last0) begin                    // Wrap to the row start
                c0   <= '0;
                off0 <= '0;
            end else begin
                c0   <= c0 + 1'b1;
                off0 <= off0 + stride0;
            end
        end
    end

    // Outer dimension, stepping once per finished row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c1   <= '0;
            off1 <= '0;
        end else if (clr) begin
            c1   <= '0;
            off1 <= '0;
        end else if (en && last0) begin
            if (last1) begin                    // Whole block done, start over
                c1   <= '0;
                off1 <= '0;
            end else begin
                c1   <= c1 + 1'b1;
                off1 <= off1 + stride1;
            end
        end
    end

    // A block always closes on a row boundary
    a_block_row : assert property (
        @(posedge clk) disable iff (!rst_n)
        block_end |-> row_end
    );

endmodule

/* hdl/quant_writeback.sv */
`timescale 1ns/1ps

module quant_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                quant_start,    // Accumulated result is ready
    input  mvu_pkg::prec_t      oprecision,     // Output bits minus one
    input  logic                base_load,      // Load the output base address
    input  mvu_pkg::data_addr_t obaseaddr,      // Output base address
    output logic                quant_load,     // Quantizer captures the result
    output logic                quant_step,     // Quantizer emits one bit plane
    output logic                wrd_en,         // Data memory write enable
    output mvu_pkg::data_addr_t wrd_addr        // Data memory write address
);

    import mvu_pkg::*;

    prec_t          step_cnt;                   // Steps left after this one
    data_addr_t     out_addr;                   // Output address register
    logic           busy;
    logic [BPREC:0] steps_seen;                 // Steps issued so far in this burst
    prec_t          steps_max;                  // Precision captured for this burst

    assign busy = quant_load || quant_step;

    // Serial sequencer of one load followed by oprecision+1 steps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quant_load <= 1'b0;
            quant_step <= 1'b0;
            step_cnt   <= '0;
        end else begin
            quant_load <= quant_start && !busy; // Ignore starts mid-sequence
            if (quant_load) begin
                quant_step <= 1'b1;
                step_cnt   <= oprecision;       // Precision sampled at load
            end else if (quant_step) begin
                if (step_cnt == '0) begin
                    quant_step <= 1'b0;         // Back to idle
                end else begin
                    step_cnt <= step_cnt - 1'b1;
                end
            end
        end
    end

    // One output word per bit plane, written upward from the base
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_addr <= '0;
        end else if (base_load) begin
            out_addr <= obaseaddr;
        end else if (quant_step) begin
            out_addr <= out_addr + 1'b1;        // Next word after this write
        end
    end

    assign wrd_en   = quant_step;
    assign wrd_addr = out_addr;

    // Burst length bookkeeping for the step bound
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            steps_seen <= '0;
            steps_max  <= '0;
        end else if (quant_load) begin
            steps_seen <= '0;
            steps_max  <= oprecision;
        end else if (quant_step) begin
            steps_seen <= steps_seen + 1'b1;
        end
    end

    a_load_step : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(quant_load && quant_step)
    );

    // A burst never runs past oprecision+1 steps
    a_step_len : assert property (
        @(posedge clk) disable iff (!rst_n)
        quant_step |-> (steps_seen <= {1'b0, steps_max})
    );

endmodule

/* hdl/mvu_ctrl_top.sv */
`timescale 1ns/1ps

module mvu_ctrl_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,        // Job start pulse
    input  mvu_pkg::cntdwn_t      countdown,    // Run window in cycles
    input  mvu_pkg::data_addr_t   ibaseaddr,    // Input base address
    input  mvu_pkg::data_addr_t   istride_0,    // Input stride along a row
    input  mvu_pkg::data_addr_t   istride_1,    // Input stride between rows
    input  mvu_pkg::length_t      ilength_0,    // Input row length minus one
    input  mvu_pkg::length_t      ilength_1,    // Input row count minus one
    input  mvu_pkg::weight_addr_t wbaseaddr,    // Weight base address
    input  mvu_pkg::weight_addr_t wstride_0,
    input  mvu_pkg::weight_addr_t wstride_1,
    input  mvu_pkg::length_t      wlength_0,
    input  mvu_pkg::length_t      wlength_1,
    input  mvu_pkg::data_addr_t   obaseaddr,    // Output base address
    input  mvu_pkg::prec_t        oprecision,   // Output bits minus one
    output logic                  run,
    output logic                  done,
    output logic                  irq,
    output mvu_pkg::data_addr_t   rdd_addr,     // Input memory read address
    output mvu_pkg::weight_addr_t rdw_addr,     // Weight memory read address
    output logic                  shacc_load,   // Accumulator load
    output logic                  shacc_acc,    // Accumulator accumulate
    output logic                  shacc_sh,     // Accumulator shift
    output logic                  quant_load,
    output logic                  quant_step,
    output logic                  wrd_en,       // Output write enable
    output mvu_pkg::data_addr_t   wrd_addr      // Output write address
);

    import mvu_pkg::*;

    logic agu_clr;                              // Accepted start only
    logic agu_row_end;                          // Input AGU row boundary
    logic agu_block_end;                        // Input AGU block boundary
    logic shacc_load_start;                     // First load of a job
    logic shacc_done;                           // Accumulation of a block done
    logic maxpool_done;                         // Quantizer start
    logic outload;                              // Output base load

    assign agu_clr = start && !run;

    mvu_controller i_mvu_controller (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .countdown (countdown),
        .run       (run),
        .done      (done),
        .irq       (irq)
    );

    mvu_agu #(.addr_t(data_addr_t)) i_inagu (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (agu_clr),
        .en        (run),
        .base_addr (ibaseaddr),
        .stride0   (istride_0),
        .stride1   (istride_1),
        .length0   (ilength_0),
        .length1   (ilength_1),
        .addr      (rdd_addr),
        .row_end   (agu_row_end),
        .block_end (agu_block_end)
    );

    // Weight walk shares the run window, its flags have no consumer
    mvu_agu #(.addr_t(weight_addr_t)) i_wagu (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (agu_clr),
        .en        (run),
        .base_addr (wbaseaddr),
        .stride0   (wstride_0),
        .stride1   (wstride_1),
        .length0   (wlength_0),
        .length1   (wlength_1),
        .addr      (rdw_addr),
        .row_end   (),
        .block_end ()
    );

    // Retime controls to meet the data at the accumulators
    delay_line #(.DEPTH(SH_DELAY)) i_dly_sh (
        .clk (clk), .rst_n (rst_n), .din (agu_row_end), .dout (shacc_sh)
    );
    delay_line #(.DEPTH(ACC_DELAY)) i_dly_acc (
        .clk (clk), .rst_n (rst_n), .din (run), .dout (shacc_acc)
    );
    delay_line #(.DEPTH(ACC_DELAY)) i_dly_load (
        .clk (clk), .rst_n (rst_n), .din (start), .dout (shacc_load_start)
    );
    delay_line #(.DEPTH(ACC_DELAY)) i_dly_done (
        .clk (clk), .rst_n (rst_n), .din (agu_block_end), .dout (shacc_done)
    );
    delay_line #(.DEPTH(MAXPOOLSTAGES)) i_dly_maxpool (
        .clk (clk), .rst_n (rst_n), .din (shacc_done), .dout (maxpool_done)
    );
    delay_line #(.DEPTH(OUTLOAD_DELAY)) i_dly_outload (
        .clk (clk), .rst_n (rst_n), .din (start), .dout (outload)
    );

    // Reload the accumulators at job start and after each finished block
    assign shacc_load = shacc_load_start | shacc_done;

    quant_writeback i_quant_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .quant_start (maxpool_done),
        .oprecision  (oprecision),
        .base_load   (outload),
        .obaseaddr   (obaseaddr),
        .quant_load  (quant_load),
        .quant_step  (quant_step),
        .wrd_en      (wrd_en),
        .wrd_addr    (wrd_addr)
    );

endmodule

/* tb/mvu_ctrl_tb.sv */
`timescale 1ns/1ps

module mvu_ctrl_tb;

    import mvu_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         start;
    cntdwn_t      countdown;
    data_addr_t   ibaseaddr, istride_0, istride_1;
    length_t      ilength_0, ilength_1;
    weight_addr_t wbaseaddr, wstride_0, wstride_1;
    length_t      wlength_0, wlength_1;
    data_addr_t   obaseaddr;
    prec_t        oprecision;
    logic         run, done, irq;
    data_addr_t   rdd_addr;
    weight_addr_t rdw_addr;
    logic         shacc_load, shacc_acc, shacc_sh;
    logic         quant_load, quant_step, wrd_en;
    data_addr_t   wrd_addr;

    mvu_ctrl_top i_mvu_ctrl_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    // Reference model state
    cntdwn_t      m_left;                       // Run cycles still to come
    logic         m_done, m_irq;
    length_t      m_ic0, m_ic1, m_wc0, m_wc1;   // Element and row counters
    logic [4:0]   row_hist;                     // Row end history, bit n is n+1 cycles ago
    logic [5:0]   run_hist;
    logic [6:0]   start_hist, blk_hist;
    logic         m_qload;
    logic [BPREC:0] m_qleft;                    // Quantizer steps still to come
    data_addr_t   m_waddr;

    logic         exp_run, accept, m_row_end, m_blk_end, exp_step;
    data_addr_t   exp_rdd;
    weight_addr_t exp_rdw;

    assign exp_run   = (m_left != '0);
    assign accept    = start && !exp_run;       // Starts count only when idle
    assign m_row_end = exp_run && (m_ic0 == ilength_0);
    assign m_blk_end = m_row_end && (m_ic1 == ilength_1);
    assign exp_step  = (m_qleft != '0);

    // Address of the k-th element straight from the strided formula
    assign exp_rdd = ibaseaddr + data_addr_t'(m_ic0 * istride_0) + data_addr_t'(m_ic1 * istride_1);
    assign exp_rdw = wbaseaddr + weight_addr_t'(m_wc0 * wstride_0)
                     + weight_addr_t'(m_wc1 * wstride_1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_left     <= '0;
            m_done     <= 1'b0;
            m_irq      <= 1'b0;
            m_ic0      <= '0;
            m_ic1      <= '0;
            m_wc0      <= '0;
            m_wc1      <= '0;
            row_hist   <= '0;
            run_hist   <= '0;
            start_hist <= '0;
            blk_hist   <= '0;
            m_qload    <= 1'b0;
            m_qleft    <= '0;
            m_waddr    <= '0;
        end else begin
            if (accept) begin
                m_left <= countdown;
                m_done <= (countdown == '0);    // Empty job is done right away
                m_irq  <= (countdown == '0);
            end else if (exp_run) begin
                m_left <= m_left - 1'b1;
                m_done <= (m_left == 1);        // Last run cycle ends the job
                m_irq  <= (m_left == 1);
            end else begin
                m_irq <= 1'b0;
            end
            if (accept) begin
                m_ic0 <= '0;
                m_ic1 <= '0;
                m_wc0 <= '0;
                m_wc1 <= '0;
            end else if (exp_run) begin
                m_ic0 <= (m_ic0 == ilength_0) ? '0 : m_ic0 + 1'b1;
                if (m_ic0 == ilength_0)
                    m_ic1 <= (m_ic1 == ilength_1) ? '0 : m_ic1 + 1'b1;
                m_wc0 <= (m_wc0 == wlength_0) ? '0 : m_wc0 + 1'b1;
                if (m_wc0 == wlength_0)
                    m_wc1 <= (m_wc1 == wlength_1) ? '0 : m_wc1 + 1'b1;
            end
            row_hist   <= {row_hist[3:0], m_row_end};
            run_hist   <= {run_hist[4:0], exp_run};
            start_hist <= {start_hist[5:0], start};
            blk_hist   <= {blk_hist[5:0], m_blk_end};
            m_qload    <= blk_hist[6] && !m_qload && !exp_step;    // Busy drops new starts
            if (m_qload)
                m_qleft <= oprecision + 1'b1;
            else if (exp_step)
                m_qleft <= m_qleft - 1'b1;
            if (start_hist[6])
                m_waddr <= obaseaddr;
            else if (exp_step)
                m_waddr <= m_waddr + 1'b1;      // One word per step
        end
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        fail_stop($sformatf("ERROR %s dut=0x%0h expected=0x%0h", name, got, exp));
    endtask

    a_run : assert property (@(posedge clk) disable iff (!rst_n) run == exp_run)
        else mismatch("run", $sampled(run), $sampled(exp_run));
    a_done : assert property (@(posedge clk) disable iff (!rst_n) done == m_done)
        else mismatch("done", $sampled(done), $sampled(m_done));
    a_irq : assert property (@(posedge clk) disable iff (!rst_n) irq == m_irq)
        else mismatch("irq", $sampled(irq), $sampled(m_irq));
    a_rdd : assert property (@(posedge clk) disable iff (!rst_n) exp_run |-> rdd_addr == exp_rdd)
        else mismatch("rdd_addr", $sampled(rdd_addr), $sampled(exp_rdd));
    a_rdw : assert property (@(posedge clk) disable iff (!rst_n) exp_run |-> rdw_addr == exp_rdw)
        else mismatch("rdw_addr", $sampled(rdw_addr), $sampled(exp_rdw));
    a_sh : assert property (@(posedge clk) disable iff (!rst_n) shacc_sh == row_hist[4])
        else mismatch("shacc_sh", $sampled(shacc_sh), $sampled(row_hist[4]));
    a_acc : assert property (@(posedge clk) disable iff (!rst_n) shacc_acc == run_hist[5])
        else mismatch("shacc_acc", $sampled(shacc_acc), $sampled(run_hist[5]));
    a_load : assert property (@(posedge clk) disable iff (!rst_n)
        shacc_load == (start_hist[5] || blk_hist[5]))
        else mismatch("shacc_load", $sampled(shacc_load), $sampled(start_hist[5] || blk_hist[5]));
    a_qload : assert property (@(posedge clk) disable iff (!rst_n) quant_load == m_qload)
        else mismatch("quant_load", $sampled(quant_load), $sampled(m_qload));
    a_qstep : assert property (@(posedge clk) disable iff (!rst_n) quant_step == exp_step)
        else mismatch("quant_step", $sampled(quant_step), $sampled(exp_step));
    a_wren : assert property (@(posedge clk) disable iff (!rst_n) wrd_en == exp_step)
        else mismatch("wrd_en", $sampled(wrd_en), $sampled(exp_step));
    a_wraddr : assert property (@(posedge clk) disable iff (!rst_n) wrd_addr == m_waddr)
        else mismatch("wrd_addr", $sampled(wrd_addr), $sampled(m_waddr));

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        @(negedge clk);                         // Sample away from the drive edge
        while (!done && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (!done)
            fail_stop($sformatf("Timed out waiting for done after %0d cycles", limit));
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        repeat (10) @(negedge clk);             // Past the 8 cycle block end to quant_load path
        while ((quant_load || quant_step) && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (quant_load || quant_step)
            fail_stop("Quantizer still busy when the wait ran out");
    endtask

    // One job with fresh random configuration, countdown = reps blocks plus tail
    task automatic run_job(input int reps, input int tail, input bit poke);
        int      l0;
        int      l1;
        cntdwn_t cd;
        l0 = $urandom_range(3, 0);
        l1 = $urandom_range(3, 0);
        cd = cntdwn_t'((l0 + 1) * (l1 + 1) * reps + tail);
        ibaseaddr  <= data_addr_t'($urandom);
        istride_0  <= data_addr_t'($urandom);
        istride_1  <= data_addr_t'($urandom);
        ilength_0  <= length_t'(l0);
        ilength_1  <= length_t'(l1);
        wbaseaddr  <= weight_addr_t'($urandom);
        wstride_0  <= weight_addr_t'($urandom);
        wstride_1  <= weight_addr_t'($urandom);
        wlength_0  <= length_t'($urandom_range(3, 0));
        wlength_1  <= length_t'($urandom_range(3, 0));
        obaseaddr  <= data_addr_t'($urandom);
        oprecision <= prec_t'($urandom);
        countdown  <= cd;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (poke) begin
            @(posedge clk);
            start <= 1'b1;                      // Lands mid-run
            @(posedge clk);
            start <= 1'b0;
        end
        $display("job countdown %0d, lengths %0d x %0d", cd, l0 + 1, l1 + 1);
        wait_done(int'(cd) + 20);
        wait_idle(200);
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'hd059_99e2));
        rst_n      = 1'b0;
        start      = 1'b0;
        countdown  = '0;
        ibaseaddr  = '0;
        istride_0  = '0;
        istride_1  = '0;
        ilength_0  = '0;
        ilength_1  = '0;
        wbaseaddr  = '0;
        wstride_0  = '0;
        wstride_1  = '0;
        wlength_0  = '0;
        wlength_1  = '0;
        obaseaddr  = '0;
        oprecision = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        run_job(1, 0, 1'b0);
        run_job(1, 0, 1'b0);
        run_job(1, 3, 1'b1);                    // Extra cycles make room for the ignored start
        run_job(3, 2, 1'b0);                    // Long job, both AGUs wrap
        run_job(1, 0, 1'b0);
        run_job(0, 0, 1'b0);                    // Empty job
        run_job(1, 0, 1'b0);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* flist.f */
common/mvu_pkg.sv
hdl/delay_line.sv
hdl/mvu_controller.sv
agu/mvu_agu.sv
hdl/quant_writeback.sv
hdl/mvu_ctrl_top.sv
tb/mvu_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MVU control lane testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module mvu_ctrl_tb \
    -f flist.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vmvu_ctrl_tb > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
